// File: verilog/sdram_pkg.sv
package sdram_pkg;

  // ----------------------------------------------------------
  // field widths and address split
  // ----------------------------------------------------------
  localparam int ADDR_W    = 26;
  localparam int ROW_W     = 12;  // addr[25:14]
  localparam int BANK_W    = 2;   // addr[13:12]
  localparam int COL_W     = 12;  // addr[11:0]
  localparam int SD_ADDR_W = 13;
  localparam int MASK_W    = 4;

  localparam int BANK_LSB = COL_W;
  localparam int ROW_LSB  = COL_W + BANK_W;

  typedef enum logic [2:0] {
    NOOP = 3'd7,
    ACTV = 3'd3,
    READ = 3'd5,
    WRTE = 3'd4,
    PRCH = 3'd2,
    ARSR = 3'd1
  } sdram_cmd_e;

  localparam logic [SD_ADDR_W-1:0] PRCH_ALL_ADDR = 13'h0400;  // a10 only

  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
  } port_req_t;

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
  } page_t;

  typedef struct packed {
    logic  page_open;
    page_t open_page;
    logic  last_was_write;
    logic  refresh_due;
    logic  actv_settled;
    logic  ready;
  } tracker_status_t;

  typedef struct packed {
    sdram_cmd_e           cmd;
    logic [SD_ADDR_W-1:0] addr;
    logic [BANK_W-1:0]    bank;
  } sd_bus_t;

  // ----------------------------------------------------------
  // address helpers
  // ----------------------------------------------------------
  function automatic page_t page_of(input logic [ADDR_W-1:0] addr);
    page_t p;
    p.bank = addr[BANK_LSB +: BANK_W];
    p.row  = addr[ROW_LSB +: ROW_W];
    return p;
  endfunction

  function automatic logic [SD_ADDR_W-1:0] col_addr(input logic [ADDR_W-1:0] addr);
    return {addr[COL_W-1:0], 1'b0};
  endfunction

  // a10 kept clear so ACTV never looks like precharge-all
  function automatic logic [SD_ADDR_W-1:0] row_addr(input logic [ROW_W-1:0] row);
    return {row[11:10], 1'b0, row[9:0]};
  endfunction

endpackage

// File: verilog/request_capture.sv
module request_capture (
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  sdram_pkg::port_req_t      rand_port,
  input  sdram_pkg::port_req_t      bulk_port,
  input  sdram_pkg::tracker_status_t status,
  output sdram_pkg::port_req_t      cap_rand,
  output sdram_pkg::port_req_t      cap_bulk,
  output logic                      hit_rand,
  output logic                      hit_bulk
);

  sdram_pkg::page_t page_rand;
  sdram_pkg::page_t page_bulk;
  logic             page_usable;
  logic             hit_rand_w;
  logic             hit_bulk_w;

  // ----------------------------------------------------------
  // page compare on the live requests
  // ----------------------------------------------------------
  assign page_rand = sdram_pkg::page_of(rand_port.addr);
  assign page_bulk = sdram_pkg::page_of(bulk_port.addr);

  // no hits while a refresh is owed, so the page gets closed
  assign page_usable = status.page_open && !status.refresh_due;

  always_comb
  begin
    hit_rand_w = 1'b0;
    hit_bulk_w = 1'b0;
    if (page_usable)
    begin
      hit_rand_w = rand_port.req && (page_rand == status.open_page);
      hit_bulk_w = bulk_port.req && (page_bulk == status.open_page);
    end
  end

  // ----------------------------------------------------------
  // capture registers
  // ----------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cap_rand.req <= 1'b0;
      cap_bulk.req <= 1'b0;
      hit_rand     <= 1'b0;
      hit_bulk     <= 1'b0;
    end
    else
    begin
      cap_rand <= rand_port;
      cap_bulk <= bulk_port;
      hit_rand <= hit_rand_w;  // lines up with cap_rand
      hit_bulk <= hit_bulk_w;
    end
  end

endmodule

// File: verilog/command_select.sv
module command_select (
  input  logic                            INPUT_CLK,
  input  logic                            RST,
  input  sdram_pkg::port_req_t            cap_rand,
  input  sdram_pkg::port_req_t            cap_bulk,
  input  logic                            hit_rand,
  input  logic                            hit_bulk,
  input  sdram_pkg::tracker_status_t      status,
  output sdram_pkg::sd_bus_t              sd_bus,
  output logic                            grant_rand,
  output logic                            grant_bulk,
  output logic [sdram_pkg::MASK_W-1:0]    we_mask
);

  sdram_pkg::sdram_cmd_e              nxt_cmd;
  logic [sdram_pkg::SD_ADDR_W-1:0]    nxt_addr;
  logic [sdram_pkg::BANK_W-1:0]       nxt_bank;
  logic [sdram_pkg::MASK_W-1:0]       nxt_mask;
  logic                               nxt_grant_rand;
  logic                               nxt_grant_bulk;
  sdram_pkg::page_t                   page_rand;
  sdram_pkg::page_t                   page_bulk;
  sdram_pkg::page_t                   page_actv;
  logic                               any_pending;
  logic                               miss_pending;

  assign page_rand = sdram_pkg::page_of(cap_rand.addr);
  assign page_bulk = sdram_pkg::page_of(cap_bulk.addr);
  assign page_actv = cap_bulk.req ? page_bulk : page_rand;  // bulk opens first

  assign any_pending  = cap_bulk.req || cap_rand.req;
  assign miss_pending = (cap_bulk.req && !hit_bulk) || (cap_rand.req && !hit_rand);

  // ----------------------------------------------------------
  // priority pick
  // ----------------------------------------------------------
  always_comb
  begin
    nxt_cmd        = sdram_pkg::NOOP;
    nxt_addr       = sd_bus.addr;
    nxt_bank       = sd_bus.bank;
    nxt_mask       = we_mask;
    nxt_grant_rand = 1'b0;
    nxt_grant_bulk = 1'b0;
    if (status.ready)
    begin
      if (hit_bulk)
      begin
        nxt_cmd        = cap_bulk.we ? sdram_pkg::WRTE : sdram_pkg::READ;
        nxt_addr       = sdram_pkg::col_addr(cap_bulk.addr);
        nxt_bank       = page_bulk.bank;
        nxt_mask       = cap_bulk.mask;
        nxt_grant_bulk = 1'b1;
      end
      else if (hit_rand)
      begin
        nxt_cmd        = cap_rand.we ? sdram_pkg::WRTE : sdram_pkg::READ;
        nxt_addr       = sdram_pkg::col_addr(cap_rand.addr);
        nxt_bank       = page_rand.bank;
        nxt_mask       = cap_rand.mask;
        nxt_grant_rand = 1'b1;
      end
      else if (status.page_open)
      begin
        // close the page for a refresh or a miss, once tRAS is met
        if ((status.refresh_due || miss_pending) && status.actv_settled)
        begin
          nxt_cmd  = sdram_pkg::PRCH;
          nxt_addr = sdram_pkg::PRCH_ALL_ADDR;
          nxt_bank = status.open_page.bank;
        end
      end
      else if (status.refresh_due)
      begin
        nxt_cmd  = sdram_pkg::ARSR;
        nxt_addr = sdram_pkg::PRCH_ALL_ADDR;
        nxt_bank = '0;
      end
      else if (any_pending)
      begin
        nxt_cmd  = sdram_pkg::ACTV;
        nxt_addr = sdram_pkg::row_addr(page_actv.row);
        nxt_bank = page_actv.bank;
      end
    end
  end

  // ----------------------------------------------------------
  // command bus and grant registers
  // ----------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      sd_bus.cmd  <= sdram_pkg::NOOP;
      sd_bus.addr <= sdram_pkg::PRCH_ALL_ADDR;
      sd_bus.bank <= '0;
      grant_rand  <= 1'b0;
      grant_bulk  <= 1'b0;
      we_mask     <= '0;
    end
    else
    begin
      sd_bus.cmd  <= nxt_cmd;  // one cycle, NOOP otherwise
      sd_bus.addr <= nxt_addr;
      sd_bus.bank <= nxt_bank;
      grant_rand  <= nxt_grant_rand;
      grant_bulk  <= nxt_grant_bulk;
      we_mask     <= nxt_mask;
    end
  end

endmodule

// File: verilog/bank_tracker.sv
module bank_tracker #(
  parameter int T_CMD_WAIT = 2,
  parameter int T_RFC_WAIT = 10,
  parameter int T_RAS_WAIT = 4
) (
  input  logic                       INPUT_CLK,
  input  logic                       RST,
  input  logic                       refresh_strobe,
  input  sdram_pkg::sd_bus_t         sd_bus,
  output sdram_pkg::tracker_status_t status
);

  // the command cycle itself already counts as one cycle of wait
  localparam int CMD_LOAD = (T_CMD_WAIT > 0) ? T_CMD_WAIT - 1 : 0;
  localparam int RFC_LOAD = (T_RFC_WAIT > 0) ? T_RFC_WAIT - 1 : 0;
  localparam int RAS_LOAD = (T_RAS_WAIT > 2) ? T_RAS_WAIT - 2 : 0;
  localparam int MAX_WAIT = (T_RFC_WAIT > T_CMD_WAIT) ? T_RFC_WAIT : T_CMD_WAIT;
  localparam int TMR_W    = $clog2(MAX_WAIT + 1);
  localparam int RAS_W    = $clog2(RAS_LOAD + 2);

  logic [TMR_W-1:0]  wait_cnt;
  logic [RAS_W-1:0]  settle_cnt;
  logic              page_open;
  sdram_pkg::page_t  open_page;
  logic              last_was_write;
  logic              strobe_q;
  logic              refresh_ack;
  logic              cmd_seen;

  assign cmd_seen = (sd_bus.cmd != sdram_pkg::NOOP);

  // ----------------------------------------------------------
  // page, refresh and timer state
  // ----------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      wait_cnt       <= TMR_W'(MAX_WAIT);  // initial wait
      settle_cnt     <= '0;
      page_open      <= 1'b0;
      open_page      <= '0;
      last_was_write <= 1'b0;
      strobe_q       <= 1'b0;
      refresh_ack    <= 1'b0;
    end
    else
    begin
      strobe_q <= refresh_strobe;
      if (wait_cnt != '0)
        wait_cnt <= wait_cnt - 1'b1;
      if (settle_cnt != '0)
        settle_cnt <= settle_cnt - 1'b1;

      case (sd_bus.cmd)
        sdram_pkg::ACTV:
        begin
          page_open      <= 1'b1;
          open_page.bank <= sd_bus.bank;
          open_page.row  <= {sd_bus.addr[12:11], sd_bus.addr[9:0]};  // undo row rule
          wait_cnt       <= TMR_W'(CMD_LOAD);
          settle_cnt     <= RAS_W'(RAS_LOAD);
        end
        sdram_pkg::PRCH:
        begin
          page_open <= 1'b0;
          wait_cnt  <= TMR_W'(CMD_LOAD);
        end
        sdram_pkg::READ:
        begin
          last_was_write <= 1'b0;
          wait_cnt       <= TMR_W'(CMD_LOAD);
        end
        sdram_pkg::WRTE:
        begin
          last_was_write <= 1'b1;
          wait_cnt       <= TMR_W'(CMD_LOAD);
        end
        sdram_pkg::ARSR:
        begin
          refresh_ack <= strobe_q;  // pays off the owed refresh
          wait_cnt    <= TMR_W'(RFC_LOAD);
        end
        default:
        begin
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // status out
  // ----------------------------------------------------------
  assign status.page_open      = page_open;
  assign status.open_page      = open_page;
  assign status.last_was_write = last_was_write;
  assign status.refresh_due    = strobe_q ^ refresh_ack;
  assign status.actv_settled   = (settle_cnt == '0);
  assign status.ready          = (wait_cnt == '0) && !cmd_seen;  // low while bus busy

endmodule

// File: verilog/sdram_scheduler.sv
module sdram_scheduler #(
  parameter int T_CMD_WAIT = 2,
  parameter int T_RFC_WAIT = 10,
  parameter int T_RAS_WAIT = 4
) (
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  sdram_pkg::port_req_t         rand_port,
  input  sdram_pkg::port_req_t         bulk_port,
  input  logic                         refresh_strobe,
  output sdram_pkg::sd_bus_t           sd_bus,
  output logic                         grant_rand,
  output logic                         grant_bulk,
  output logic [sdram_pkg::MASK_W-1:0] we_mask
);

  sdram_pkg::port_req_t       cap_rand;
  sdram_pkg::port_req_t       cap_bulk;
  logic                       hit_rand;
  logic                       hit_bulk;
  sdram_pkg::tracker_status_t status;

  // stage 1
  request_capture u_capture (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .rand_port (rand_port),
    .bulk_port (bulk_port),
    .status    (status),
    .cap_rand  (cap_rand),
    .cap_bulk  (cap_bulk),
    .hit_rand  (hit_rand),
    .hit_bulk  (hit_bulk)
  );

  // stage 2
  command_select u_select (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .cap_rand   (cap_rand),
    .cap_bulk   (cap_bulk),
    .hit_rand   (hit_rand),
    .hit_bulk   (hit_bulk),
    .status     (status),
    .sd_bus     (sd_bus),
    .grant_rand (grant_rand),
    .grant_bulk (grant_bulk),
    .we_mask    (we_mask)
  );

  // stage 3, status fed back to stages 1 and 2
  bank_tracker #(
    .T_CMD_WAIT (T_CMD_WAIT),
    .T_RFC_WAIT (T_RFC_WAIT),
    .T_RAS_WAIT (T_RAS_WAIT)
  ) u_tracker (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .sd_bus         (sd_bus),
    .status         (status)
  );

endmodule

// File: tests/sdram_scheduler_properties.sv
module sdram_scheduler_properties #(
  parameter int T_CMD_WAIT = 2,
  parameter int T_RFC_WAIT = 10,
  parameter int T_RAS_WAIT = 4
) (
  input logic                         INPUT_CLK,
  input logic                         RST,
  input sdram_pkg::port_req_t         rand_port,
  input sdram_pkg::port_req_t         bulk_port,
  input logic                         refresh_strobe,
  input sdram_pkg::sd_bus_t           sd_bus,
  input logic                         grant_rand,
  input logic                         grant_bulk,
  input logic [sdram_pkg::MASK_W-1:0] we_mask
);

  int          err_count = 0;
  logic        shadow_open;
  logic [1:0]  shadow_bank;
  logic [11:0] shadow_row;
  logic        seen_cmd;
  logic        last_arsr;
  int          since_cmd;
  int          since_actv;
  int          owed;
  logic        strobe_d;
  logic        is_rw;
  logic        toggle;

  assign is_rw  = (sd_bus.cmd == sdram_pkg::READ) || (sd_bus.cmd == sdram_pkg::WRTE);
  assign toggle = (refresh_strobe != strobe_d);

  // ----------------------------------------------------------
  // shadow of the page and the refresh debt
  // ----------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      shadow_open <= 1'b0;
      shadow_bank <= '0;
      shadow_row  <= '0;
      seen_cmd    <= 1'b0;
      last_arsr   <= 1'b0;
      since_cmd   <= 0;
      since_actv  <= 0;
      owed        <= 0;
      strobe_d    <= 1'b0;
    end
    else
    begin
      strobe_d <= refresh_strobe;
      if (since_cmd < 1000)
        since_cmd <= since_cmd + 1;
      if (since_actv < 1000)
        since_actv <= since_actv + 1;
      if (sd_bus.cmd != sdram_pkg::NOOP)
      begin
        seen_cmd  <= 1'b1;
        since_cmd <= 1;
        last_arsr <= (sd_bus.cmd == sdram_pkg::ARSR);
      end
      if (sd_bus.cmd == sdram_pkg::ACTV)
      begin
        shadow_open <= 1'b1;
        shadow_bank <= sd_bus.bank;
        shadow_row  <= {sd_bus.addr[12:11], sd_bus.addr[9:0]};  // row rule reversed
        since_actv  <= 1;
      end
      if (sd_bus.cmd == sdram_pkg::PRCH)
        shadow_open <= 1'b0;
      if (toggle && sd_bus.cmd != sdram_pkg::ARSR)
        owed <= owed + 1;
      else if (!toggle && sd_bus.cmd == sdram_pkg::ARSR)
        owed <= owed - 1;
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_reset_idle: assert property (@(posedge INPUT_CLK)
    (RST && !seen_cmd) |-> (!grant_rand && !grant_bulk && we_mask == '0 && !is_rw))
    else begin $error("outputs not idle after reset"); err_count++; end

  a_rw_granted: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    is_rw |-> (grant_rand ^ grant_bulk))
    else begin $error("read/write without a single grant"); err_count++; end

  a_grant_bulk: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    grant_bulk |-> ($past(bulk_port.req) && is_rw
      && (sd_bus.cmd == ($past(bulk_port.we) ? sdram_pkg::WRTE : sdram_pkg::READ))
      && we_mask == $past(bulk_port.mask)
      && sd_bus.addr == {$past(bulk_port.addr[11:0]), 1'b0}
      && sd_bus.bank == $past(bulk_port.addr[13:12])
      && shadow_open && shadow_bank == $past(bulk_port.addr[13:12])
      && shadow_row == $past(bulk_port.addr[25:14])))
    else begin $error("bulk grant does not match its request"); err_count++; end

  a_grant_rand: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    grant_rand |-> ($past(rand_port.req) && is_rw
      && (sd_bus.cmd == ($past(rand_port.we) ? sdram_pkg::WRTE : sdram_pkg::READ))
      && we_mask == $past(rand_port.mask)
      && sd_bus.addr == {$past(rand_port.addr[11:0]), 1'b0}
      && sd_bus.bank == $past(rand_port.addr[13:12])
      && shadow_open && shadow_bank == $past(rand_port.addr[13:12])
      && shadow_row == $past(rand_port.addr[25:14])))
    else begin $error("random grant does not match its request"); err_count++; end

  // same page on both ports means bulk must win
  a_bulk_first: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    grant_rand |-> !($past(bulk_port.req, 2)
      && $past(bulk_port.addr[25:12], 2) == $past(rand_port.addr[25:12], 2)))
    else begin $error("random port served ahead of a bulk hit"); err_count++; end

  a_actv: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (sd_bus.cmd == sdram_pkg::ACTV) |-> (!shadow_open && !sd_bus.addr[10]))
    else begin $error("bad activate"); err_count++; end

  a_cmd_gap: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (sd_bus.cmd != sdram_pkg::NOOP && seen_cmd)
      |-> (since_cmd >= (last_arsr ? T_RFC_WAIT + 1 : T_CMD_WAIT + 1)))
    else begin $error("command issued too early"); err_count++; end

  a_ras: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (sd_bus.cmd == sdram_pkg::PRCH) |-> (shadow_open && since_actv >= T_RAS_WAIT))
    else begin $error("precharge before tRAS"); err_count++; end

  a_all_addr: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (sd_bus.cmd inside {sdram_pkg::PRCH, sdram_pkg::ARSR})
      |-> (sd_bus.addr == sdram_pkg::PRCH_ALL_ADDR))
    else begin $error("precharge-all address missing"); err_count++; end

  a_arsr: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (sd_bus.cmd == sdram_pkg::ARSR) |-> (!shadow_open && owed > 0))
    else begin $error("refresh with open page or none owed"); err_count++; end

  a_refresh_served: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    $changed(refresh_strobe) |-> ##[1:60] (sd_bus.cmd == sdram_pkg::ARSR))
    else begin $error("owed refresh never issued"); err_count++; end

endmodule

bind sdram_scheduler sdram_scheduler_properties #(
  .T_CMD_WAIT (T_CMD_WAIT),
  .T_RFC_WAIT (T_RFC_WAIT),
  .T_RAS_WAIT (T_RAS_WAIT)
) u_props (
  .INPUT_CLK      (INPUT_CLK),
  .RST            (RST),
  .rand_port      (rand_port),
  .bulk_port      (bulk_port),
  .refresh_strobe (refresh_strobe),
  .sd_bus         (sd_bus),
  .grant_rand     (grant_rand),
  .grant_bulk     (grant_bulk),
  .we_mask        (we_mask)
);

// File: tests/tb_sdram_scheduler.sv
module tb_sdram_scheduler;

  localparam int MAX_CYCLES    = 4000;
  localparam int N_REQ         = 30;
  localparam int REFRESH_EVERY = 150;

  logic                         INPUT_CLK;
  logic                         RST;
  sdram_pkg::port_req_t         rand_port;
  sdram_pkg::port_req_t         bulk_port;
  logic                         refresh_strobe;
  sdram_pkg::sd_bus_t           sd_bus;
  logic                         grant_rand;
  logic                         grant_bulk;
  logic [sdram_pkg::MASK_W-1:0] we_mask;

  int          seed;
  int          cycles;
  int          rand_left;
  int          bulk_left;
  int          refresh_timer;
  logic        run;
  logic        stim_done;
  logic        bulk_near;  // bulk shares the random port's rows
  logic [11:0] bulk_col;

  sdram_scheduler #(
    .T_CMD_WAIT (2),
    .T_RFC_WAIT (10),
    .T_RAS_WAIT (4)
  ) dut (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .rand_port      (rand_port),
    .bulk_port      (bulk_port),
    .refresh_strobe (refresh_strobe),
    .sd_bus         (sd_bus),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk),
    .we_mask        (we_mask)
  );

  always #5 INPUT_CLK = ~INPUT_CLK;

  function automatic logic [11:0] near_row(input int r);
    return (r & 1) ? 12'h011 : 12'h5a2;
  endfunction

  // ----------------------------------------------------------
  // request and refresh stimulus, falling edge
  // ----------------------------------------------------------
  always @(negedge INPUT_CLK)
  begin
    if (run)
    begin
      if (rand_port.req && grant_rand)
        rand_port.req = 1'b0;
      else if (!rand_port.req && rand_left > 0 && ($random(seed) & 3) != 0)
      begin
        rand_port.we   = 1'($random(seed));
        rand_port.mask = 4'($random(seed));
        rand_port.addr = {near_row($random(seed)), 2'($random(seed)), 12'($random(seed))};
        rand_port.req  = 1'b1;
        rand_left--;
      end
      if (bulk_port.req && grant_bulk)
        bulk_port.req = 1'b0;
      else if (!bulk_port.req && bulk_left > 0)
      begin
        bulk_col       = bulk_col + 12'd8;
        bulk_port.we   = 1'($random(seed));
        bulk_port.mask = 4'($random(seed));
        bulk_port.addr[25:14] = bulk_near ? near_row($random(seed)) : 12'($random(seed));
        bulk_port.addr[13:0]  = {2'($random(seed)), bulk_col};
        bulk_port.req  = 1'b1;
        bulk_left--;
      end
      if (!stim_done)
      begin
        refresh_timer++;
        if (refresh_timer == REFRESH_EVERY)
        begin
          refresh_strobe = ~refresh_strobe;
          refresh_timer  = 0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // assertion watch and timeout
  // ----------------------------------------------------------
  always @(negedge INPUT_CLK)
  begin
    cycles++;
    if (dut.u_props.err_count != 0)
    begin
      $display("[FAIL] %0t: assertion on the command bus failed", $time);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first error");
    end
    else if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic wait_ports_idle();
    while (rand_left != 0 || bulk_left != 0 || rand_port.req || bulk_port.req)
      @(posedge INPUT_CLK);
  endtask

  initial
  begin
    seed           = 32'h4041fbe3;
    INPUT_CLK      = 1'b0;
    RST            = 1'b0;
    rand_port      = '0;
    bulk_port      = '0;
    refresh_strobe = 1'b0;
    cycles         = 0;
    rand_left      = 0;
    bulk_left      = 0;
    refresh_timer  = 0;
    run            = 1'b0;
    stim_done      = 1'b0;
    bulk_near      = 1'b0;
    bulk_col       = '0;
    repeat (16) @(negedge INPUT_CLK);
    RST = 1'b1;
    @(posedge INPUT_CLK);
    run       = 1'b1;
    rand_left = N_REQ;  // two rows only
    wait_ports_idle();
    bulk_left = N_REQ;
    wait_ports_idle();
    bulk_near = 1'b1;   // both ports on shared rows
    rand_left = N_REQ;
    bulk_left = N_REQ;
    wait_ports_idle();
    stim_done = 1'b1;
    repeat (80) @(posedge INPUT_CLK);  // let the last refresh drain
    if (dut.u_props.err_count == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("SOME TESTS FAILED");
      $fatal(1, "assertion errors seen");
    end
  end

endmodule

// File: sim.f
verilog/sdram_pkg.sv
verilog/request_capture.sv
verilog/command_select.sv
verilog/bank_tracker.sv
verilog/sdram_scheduler.sv
tests/sdram_scheduler_properties.sv
tests/tb_sdram_scheduler.sv
